// File: flist.f
+incdir+rtl
rtl/cap_pkg.sv
rtl/cap_op_if.sv
rtl/cap_apb_front.sv
rtl/cap_regfile_stage.sv
rtl/cap_check_stage.sv
rtl/cap_unit_top.sv
tb/cap_checker.sv
tb/tb_cap_unit.sv

// File: tb/tb_cap_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "cap_defs.svh"

module tb_cap_unit;
  import cap_pkg::*;

  typedef struct packed {
    cap_op_e     op;
    logic [3:0]  idx;
    logic [31:0] base;
    logic [31:0] len;
    logic [1:0]  perm;
    logic [31:0] addr;
    logic        wr;
    cap_fault_e  exp;
  } row_t;

  logic        clk;
  logic        rst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        core_sleep;
  logic        want_valid;
  cap_fault_e  want_fault;
  int          err_cnt;
  int          tmo_cnt;
  logic [31:0] seed;
  row_t        rows [$];

  cap_unit_top uut (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .psel_i       (psel),
    .penable_i    (penable),
    .pwrite_i     (pwrite),
    .paddr_i      (paddr),
    .pwdata_i     (pwdata),
    .prdata_o     (prdata),
    .pready_o     (pready),
    .pslverr_o    (pslverr),
    .core_sleep_o (core_sleep)
  );

  cap_checker u_checker (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .psel_i       (psel),
    .penable_i    (penable),
    .pwrite_i     (pwrite),
    .paddr_i      (paddr),
    .pwdata_i     (pwdata),
    .prdata_i     (prdata),
    .pready_i     (pready),
    .pslverr_i    (pslverr),
    .core_sleep_i (core_sleep),
    .want_valid_i (want_valid),
    .want_fault_i (want_fault),
    .err_cnt_o    (err_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  //////////////////////
  // APB driver
  //////////////////////

  task automatic apb_xfer(input logic wr, input logic [7:0] a, input logic [31:0] d,
                          output logic [31:0] q);
    int n;
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = a;
    pwdata  = d;
    @(negedge clk);
    penable = 1'b1;
    n = 0;
    @(posedge clk);
    while (!pready && n < 10) begin
      @(posedge clk);
      n++;
    end
    if (!pready) begin
      $display("APB transfer to offset %h never got pready", a);
      tmo_cnt++;
    end
    q = prdata;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input logic [7:0] a, input logic [31:0] d);
    logic [31:0] q;
    apb_xfer(1'b1, a, d, q);
  endtask

  task automatic apb_read(input logic [7:0] a, output logic [31:0] q);
    apb_xfer(1'b0, a, 32'h0, q);
  endtask

  task automatic wait_sleep();
    int n;
    n = 0;
    while (core_sleep !== 1'b1 && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (core_sleep !== 1'b1) begin
      $display("Timeout: core_sleep_o did not return high");
      tmo_cnt++;
    end
  endtask

  // Polls RESULT until done
  task automatic run_check(input logic [3:0] idx, input logic [31:0] addr, input logic wr,
                           input logic use_want, input cap_fault_e exp);
    logic [31:0] q;
    int n;
    apb_write(`REG_CHK_ADDR, addr);
    want_fault = exp;
    want_valid = use_want;
    apb_write(`REG_CHK_GO, {27'b0, wr, idx});
    n = 0;
    q = 32'h0;
    while (!q[31] && n < 20) begin
      apb_read(`REG_RESULT, q);
      n++;
    end
    if (!q[31]) begin
      $display("Timeout: check on index %0d never finished", idx);
      tmo_cnt++;
    end
    want_valid = 1'b0;
    wait_sleep();
  endtask

  task automatic add_row(input cap_op_e op, input logic [3:0] idx, input logic [31:0] base,
                         input logic [31:0] len, input logic [1:0] perm, input logic [31:0] addr,
                         input logic wr, input cap_fault_e exp);
    row_t r;
    r = '{op, idx, base, len, perm, addr, wr, exp};
    rows.push_back(r);
  endtask

  //////////////////////
  // Stimulus table
  //////////////////////

  task automatic build_table();
    // Empty file
    add_row(OP_CHECK,  4'd3, 0, 0, 2'b00, 32'h0000_0100, 1'b0, FLT_TAG);
    add_row(OP_CHECK,  4'd15, 0, 0, 2'b00, 32'h0000_0000, 1'b1, FLT_TAG);
    // Read/write entry and its edges
    add_row(OP_COMMIT, 4'd3, 32'h1000, 32'h100, 2'b11, 0, 1'b0, FLT_NONE);
    add_row(OP_CHECK,  4'd3, 0, 0, 2'b00, 32'h0000_1000, 1'b0, FLT_NONE);
    add_row(OP_CHECK,  4'd3, 0, 0, 2'b00, 32'h0000_10FC, 1'b1, FLT_NONE);
    add_row(OP_CHECK,  4'd3, 0, 0, 2'b00, 32'h0000_0FFC, 1'b0, FLT_BOUNDS);
    add_row(OP_CHECK,  4'd3, 0, 0, 2'b00, 32'h0000_10FD, 1'b0, FLT_BOUNDS);
    add_row(OP_CHECK,  4'd3, 0, 0, 2'b00, 32'h0000_1100, 1'b1, FLT_BOUNDS);
    // Permission beats bounds
    add_row(OP_COMMIT, 4'd5, 32'h2000, 32'h40, 2'b01, 0, 1'b0, FLT_NONE);
    add_row(OP_CHECK,  4'd5, 0, 0, 2'b00, 32'h0000_2000, 1'b1, FLT_PERM);
    add_row(OP_CHECK,  4'd5, 0, 0, 2'b00, 32'h0000_3000, 1'b1, FLT_PERM);
    add_row(OP_CHECK,  4'd5, 0, 0, 2'b00, 32'h0000_2010, 1'b0, FLT_NONE);
    add_row(OP_COMMIT, 4'd6, 32'h3000, 32'h20, 2'b10, 0, 1'b0, FLT_NONE);
    add_row(OP_CHECK,  4'd6, 0, 0, 2'b00, 32'h0000_2000, 1'b0, FLT_PERM);
    add_row(OP_CHECK,  4'd6, 0, 0, 2'b00, 32'h0000_3000, 1'b1, FLT_NONE);
    // Revoke and restore
    add_row(OP_REVOKE, 4'd3, 0, 0, 2'b00, 0, 1'b0, FLT_NONE);
    add_row(OP_CHECK,  4'd3, 0, 0, 2'b00, 32'h0000_1000, 1'b0, FLT_TAG);
    add_row(OP_CHECK,  4'd5, 0, 0, 2'b00, 32'h0000_2010, 1'b0, FLT_NONE);
    add_row(OP_COMMIT, 4'd3, 32'h1000, 32'h100, 2'b11, 0, 1'b0, FLT_NONE);
    add_row(OP_CHECK,  4'd3, 0, 0, 2'b00, 32'h0000_1000, 1'b0, FLT_NONE);
    add_row(OP_COMMIT, 4'd9, 32'h0, 32'h3400, 2'b11, 0, 1'b0, FLT_NONE);
    add_row(OP_CHECK,  4'd9, 0, 0, 2'b00, 32'h0000_33FC, 1'b1, FLT_NONE);
    add_row(OP_CHECK,  4'd9, 0, 0, 2'b00, 32'h0000_33FD, 1'b0, FLT_BOUNDS);
  endtask

  initial begin
    logic [31:0] q;
    logic [3:0]  idx_pool [4];
    row_t        r;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = 8'h0;
    pwdata     = 32'h0;
    want_valid = 1'b0;
    want_fault = FLT_NONE;
    tmo_cnt    = 0;
    seed       = 32'd87;
    idx_pool   = '{4'd3, 4'd5, 4'd6, 4'd9};
    rst_n      = 1'b0;
    build_table();
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    wait_sleep();

    for (int i = 0; i < rows.size(); i++) begin
      r = rows[i];
      case (r.op)
        OP_COMMIT: begin
          apb_write(`REG_BASE, r.base);
          apb_write(`REG_LEN, r.len);
          apb_write(`REG_PERM, {30'b0, r.perm});
          apb_write(`REG_COMMIT, {28'b0, r.idx});
        end
        OP_REVOKE: apb_write(`REG_REVOKE, {28'b0, r.idx});
        default:   run_check(r.idx, r.addr, r.wr, 1'b1, r.exp);
      endcase
    end
    apb_read(`REG_FAULTS, q);

    // Unmapped and misaligned offsets and write-only readback
    apb_write(8'h24, 32'hDEAD_BEEF);
    apb_write(8'h02, 32'h0000_0001);
    apb_read(8'h24, q);
    apb_read(8'hFC, q);
    apb_read(`REG_COMMIT, q);
    apb_read(`REG_BASE, q);
    apb_read(`REG_LEN, q);
    apb_read(`REG_FAULTS, q);

    for (int i = 0; i < 12; i++) begin
      seed = lcg_next(seed);
      run_check(idx_pool[seed[17:16]], {18'b0, seed[13:12], 2'b0, seed[9:0]}, seed[20],
                1'b0, FLT_NONE);
    end
    apb_read(`REG_FAULTS, q);
    repeat (4) @(negedge clk);

    $display("Run complete: %0d mismatches, %0d timeouts", err_cnt, tmo_cnt);
    if (err_cnt == 0 && tmo_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb/cap_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "cap_defs.svh"

module cap_checker (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  input  wire logic                   psel_i,
  input  wire logic                   penable_i,
  input  wire logic                   pwrite_i,
  input  wire logic [`CAP_ADDR_W-1:0] paddr_i,
  input  wire logic [31:0]            pwdata_i,
  input  wire logic [31:0]            prdata_i,
  input  wire logic                   pready_i,
  input  wire logic                   pslverr_i,
  input  wire logic                   core_sleep_i,
  input  wire logic                   want_valid_i,
  input  wire cap_pkg::cap_fault_e    want_fault_i,
  output int                          err_cnt_o
);
  import cap_pkg::*;

  cap_t        model [`CAP_NUM];
  logic [31:0] base_m;
  logic [31:0] len_m;
  logic [1:0]  perm_m;
  logic [31:0] chk_addr_m;
  cap_fault_e  cur_fault;
  cap_fault_e  last_fault;
  logic        pend_fault;
  logic        go_seen;
  int          go_age;
  int          fault_cnt;
  int          inflight;
  int          quiet;

  function automatic logic is_mapped(input logic [7:0] a);
    case (a)
      `REG_BASE, `REG_LEN, `REG_PERM, `REG_COMMIT, `REG_CHK_ADDR,
      `REG_CHK_GO, `REG_RESULT, `REG_REVOKE, `REG_FAULTS: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // Tag, then permission, then bounds
  function automatic cap_fault_e fault_of(input cap_t c, input logic [31:0] a, input logic wr);
    logic ok;
    ok = wr ? c.perm_w : c.perm_r;
    if (!c.tag) return FLT_TAG;
    if (!ok) return FLT_PERM;
    if ((a < c.base) || (({1'b0, a} + 33'd4) > {1'b0, c.top})) return FLT_BOUNDS;
    return FLT_NONE;
  endfunction

  // Done is visible from the fourth edge after the CHK_GO access
  function automatic logic [31:0] read_value(input logic [7:0] a);
    logic done;
    done = go_seen && (go_age >= 4);
    case (a)
      `REG_BASE:     return base_m;
      `REG_LEN:      return len_m;
      `REG_PERM:     return {30'b0, perm_m};
      `REG_CHK_ADDR: return chk_addr_m;
      `REG_RESULT:   return {done, 29'b0, done ? cur_fault : last_fault};
      `REG_FAULTS:   return fault_cnt;
      default:       return 32'h0;
    endcase
  endfunction

  task automatic flag_mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
    $display("Mismatch %s: got %h expected %h", name, got, exp);
    err_cnt_o++;
  endtask

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int i = 0; i < `CAP_NUM; i++) begin
        model[i] = '0;
      end
      cur_fault  = FLT_NONE;
      last_fault = FLT_NONE;
      pend_fault = 1'b0;
      go_seen    = 1'b0;
      go_age     = 0;
      fault_cnt  = 0;
      inflight   = 0;
      quiet      = 0;
      err_cnt_o  = 0;
    end else begin
      if (go_age < 100) go_age++;
      if (go_age == 4 && pend_fault) fault_cnt++;

      //////////////////////
      // Sleep flag
      //////////////////////
      if (inflight != 0) begin
        if (core_sleep_i !== 1'b0) flag_mismatch("core_sleep_o", core_sleep_i, 32'h0);
        inflight--;
        quiet = 0;
      end else if (psel_i) begin
        quiet = 0;
      end else begin
        if (quiet < 100) quiet++;
        if (quiet >= 2 && core_sleep_i !== 1'b1) begin
          flag_mismatch("core_sleep_o", core_sleep_i, 32'h1);
        end
      end

      //////////////////////
      // APB access phase
      //////////////////////
      // No wait states
      if (psel_i && penable_i && pready_i !== 1'b1) begin
        flag_mismatch("pready_o", pready_i, 32'h1);
      end
      if (psel_i && penable_i && pready_i) begin
        if (pslverr_i !== !is_mapped(paddr_i)) begin
          flag_mismatch("pslverr_o", pslverr_i, !is_mapped(paddr_i));
        end
        if (!pwrite_i) begin
          if (prdata_i !== read_value(paddr_i)) begin
            flag_mismatch("prdata_o", prdata_i, read_value(paddr_i));
          end
          if (want_valid_i && paddr_i == `REG_RESULT && prdata_i[31] &&
              prdata_i[1:0] !== want_fault_i) begin
            flag_mismatch("prdata_o[1:0]", prdata_i[1:0], want_fault_i);
          end
        end else begin
          case (paddr_i)
            `REG_BASE:     base_m = pwdata_i;
            `REG_LEN:      len_m = pwdata_i;
            `REG_PERM:     perm_m = pwdata_i[1:0];
            `REG_CHK_ADDR: chk_addr_m = pwdata_i;
            `REG_COMMIT: begin
              model[pwdata_i[3:0]] = {base_m, base_m + len_m, perm_m[0], perm_m[1], 1'b1};
              if (inflight < 2) inflight = 2;
            end
            `REG_REVOKE: begin
              model[pwdata_i[3:0]].tag = 1'b0;
              if (inflight < 2) inflight = 2;
            end
            `REG_CHK_GO: begin
              last_fault = (go_seen && go_age >= 4) ? cur_fault : last_fault;
              cur_fault  = fault_of(model[pwdata_i[3:0]], chk_addr_m, pwdata_i[4]);
              pend_fault = (cur_fault != FLT_NONE);
              go_seen    = 1'b1;
              go_age     = 0;
              inflight   = 4;
            end
            default: ;
          endcase
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/cap_unit_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cap_defs.svh"

module cap_unit_top (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,

  // APB slave
  input  wire logic                   psel_i,
  input  wire logic                   penable_i,
  input  wire logic                   pwrite_i,
  input  wire logic [`CAP_ADDR_W-1:0] paddr_i,
  input  wire logic [31:0]            pwdata_i,
  output logic      [31:0]            prdata_o,
  output logic                        pready_o,
  output logic                        pslverr_o,

  output logic                        core_sleep_o
);
  import cap_pkg::*;

  logic       res_valid;
  cap_fault_e res_fault;
  logic       unit_busy_d;
  logic       unit_busy_q;

  cap_op_if front_op ();
  cap_op_if chk_op ();

  ////////////////////
  // Busy and sleep
  ////////////////////

  // Any stage holding work or a bus transfer in progress
  assign unit_busy_d = psel_i | front_op.valid | chk_op.valid | res_valid;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      unit_busy_q <= 1'b0;
    end else begin
      unit_busy_q <= unit_busy_d;
    end
  end

  // Sleep is only reported and the clock keeps running
  assign core_sleep_o = ~unit_busy_q;

  ////////////////////
  // Pipeline
  ////////////////////

  cap_apb_front u_front (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .psel_i      (psel_i),
    .penable_i   (penable_i),
    .pwrite_i    (pwrite_i),
    .paddr_i     (paddr_i),
    .pwdata_i    (pwdata_i),
    .prdata_o    (prdata_o),
    .pready_o    (pready_o),
    .pslverr_o   (pslverr_o),
    .res_valid_i (res_valid),
    .res_fault_i (res_fault),
    .op_o        (front_op)
  );

  cap_regfile_stage u_regfile (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .op_i   (front_op),
    .op_o   (chk_op)
  );

  cap_check_stage u_check (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .op_i        (chk_op),
    .res_valid_o (res_valid),
    .res_fault_o (res_fault)
  );

endmodule

`default_nettype wire

// File: rtl/cap_check_stage.sv
`timescale 1ns/1ps
`default_nettype none

module cap_check_stage (
  input  wire logic          clk_i,
  input  wire logic          rst_ni,

  cap_op_if.dst              op_i,

  output logic               res_valid_o,
  output cap_pkg::cap_fault_e res_fault_o
);
  import cap_pkg::*;

  logic        check_en;
  logic        perm_ok;
  logic        below_base;
  logic        past_top;
  logic [32:0] end_addr;
  cap_fault_e  fault_d;

  assign check_en = op_i.valid && (op_i.op == OP_CHECK);

  ////////////////////
  // Fault rule
  ////////////////////

  assign perm_ok = op_i.is_write ? op_i.cap.perm_w : op_i.cap.perm_r;

  // One extra bit so a word at the top of memory does not wrap
  assign end_addr   = {1'b0, op_i.addr} + 33'd4;
  assign below_base = op_i.addr < op_i.cap.base;
  assign past_top   = end_addr > {1'b0, op_i.cap.top};

  // Tag first, then permission, then bounds
  always_comb begin
    fault_d = FLT_NONE;
    if (!op_i.cap.tag) begin
      fault_d = FLT_TAG;
    end else if (!perm_ok) begin
      fault_d = FLT_PERM;
    end else if (below_base || past_top) begin
      fault_d = FLT_BOUNDS;
    end
  end

  ////////////////////
  // Result register
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      res_valid_o <= 1'b0;
    end else begin
      res_valid_o <= check_en;
    end
  end

  always_ff @(posedge clk_i) begin
    if (check_en) begin
      res_fault_o <= fault_d;
    end
  end

endmodule

`default_nettype wire

// File: rtl/cap_regfile_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "cap_defs.svh"

module cap_regfile_stage (
  input  wire logic clk_i,
  input  wire logic rst_ni,

  cap_op_if.dst     op_i,
  cap_op_if.src     op_o
);
  import cap_pkg::*;

  cap_t                  mem_q [`CAP_NUM];
  logic [`CAP_NUM-1:0]   tag_q;
  cap_t                  rd_cap;

  logic                  commit_en;
  logic                  revoke_en;
  logic                  check_en;

  logic                  chk_valid_q;
  logic [`CAP_IDX_W-1:0] chk_idx_q;
  logic                  chk_is_write_q;
  logic [31:0]           chk_addr_q;
  cap_t                  chk_cap_q;

  assign commit_en = op_i.valid && (op_i.op == OP_COMMIT);
  assign revoke_en = op_i.valid && (op_i.op == OP_REVOKE);
  assign check_en  = op_i.valid && (op_i.op == OP_CHECK);

  ////////////////////
  // Storage
  ////////////////////

  // Per-entry validity tags
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tag_q <= '0;
    end else if (commit_en) begin
      tag_q[op_i.idx] <= op_i.cap.tag;
    end else if (revoke_en) begin
      tag_q[op_i.idx] <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (commit_en) begin
      mem_q[op_i.idx] <= op_i.cap;
    end
  end

  // Operand read takes the tag from the live tag vector
  always_comb begin
    rd_cap     = mem_q[op_i.idx];
    rd_cap.tag = tag_q[op_i.idx];
  end

  ////////////////////
  // Forward to check
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      chk_valid_q <= 1'b0;
    end else begin
      chk_valid_q <= check_en;
    end
  end

  always_ff @(posedge clk_i) begin
    if (check_en) begin
      chk_idx_q      <= op_i.idx;
      chk_is_write_q <= op_i.is_write;
      chk_addr_q     <= op_i.addr;
      chk_cap_q      <= rd_cap;
    end
  end

  assign op_o.valid    = chk_valid_q;
  assign op_o.op       = OP_CHECK;
  assign op_o.idx      = chk_idx_q;
  assign op_o.is_write = chk_is_write_q;
  assign op_o.addr     = chk_addr_q;
  assign op_o.cap      = chk_cap_q;

endmodule

`default_nettype wire

// File: rtl/cap_apb_front.sv
`timescale 1ns/1ps
`default_nettype none

`include "cap_defs.svh"

module cap_apb_front (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,

  input  wire logic                   psel_i,
  input  wire logic                   penable_i,
  input  wire logic                   pwrite_i,
  input  wire logic [`CAP_ADDR_W-1:0] paddr_i,
  input  wire logic [31:0]            pwdata_i,
  output logic      [31:0]            prdata_o,
  output logic                        pready_o,
  output logic                        pslverr_o,

  input  wire logic                   res_valid_i,
  input  wire cap_pkg::cap_fault_e    res_fault_i,

  cap_op_if.src                       op_o
);
  import cap_pkg::*;

  logic                  access;
  logic                  addr_hit;
  logic                  wr_en;
  logic                  cmd_wr;

  logic [31:0]           base_q;
  logic [31:0]           len_q;
  logic [1:0]            perm_q;
  logic [31:0]           chk_addr_q;

  cap_t                  commit_cap;
  logic                  op_valid_q;
  cap_op_e               op_code_q;
  logic [`CAP_IDX_W-1:0] op_idx_q;
  logic                  op_is_write_q;
  logic [31:0]           op_addr_q;
  cap_t                  op_cap_q;

  logic                  done_q;
  cap_fault_e            fault_q;
  logic [31:0]           fault_cnt_q;

  ////////////////////
  // APB decode
  ////////////////////

  assign access = psel_i & penable_i;

  always_comb begin
    case (paddr_i)
      `REG_BASE, `REG_LEN, `REG_PERM, `REG_COMMIT, `REG_CHK_ADDR,
      `REG_CHK_GO, `REG_RESULT, `REG_REVOKE, `REG_FAULTS: addr_hit = 1'b1;
      default:                                            addr_hit = 1'b0;
    endcase
  end

  // Zero wait states
  assign pready_o  = 1'b1;
  assign pslverr_o = access & ~addr_hit;

  assign wr_en  = access & pwrite_i & addr_hit;
  assign cmd_wr = wr_en & ((paddr_i == `REG_COMMIT) | (paddr_i == `REG_REVOKE) |
                           (paddr_i == `REG_CHK_GO));

  // Command registers read back as zero
  always_comb begin
    prdata_o = '0;
    if (psel_i && !pwrite_i) begin
      case (paddr_i)
        `REG_BASE:     prdata_o = base_q;
        `REG_LEN:      prdata_o = len_q;
        `REG_PERM:     prdata_o = {30'b0, perm_q};
        `REG_CHK_ADDR: prdata_o = chk_addr_q;
        `REG_RESULT:   prdata_o = {done_q, 29'b0, fault_q};
        `REG_FAULTS:   prdata_o = fault_cnt_q;
        default:       prdata_o = '0;
      endcase
    end
  end

  ////////////////////
  // Staging registers
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      case (paddr_i)
        `REG_BASE:     base_q     <= pwdata_i;
        `REG_LEN:      len_q      <= pwdata_i;
        `REG_PERM:     perm_q     <= pwdata_i[1:0];
        `REG_CHK_ADDR: chk_addr_q <= pwdata_i;
        default:       ;
      endcase
    end
  end

  // Bit 0 read, bit 1 write
  always_comb begin
    commit_cap.base   = base_q;
    commit_cap.top    = base_q + len_q;
    commit_cap.perm_r = perm_q[0];
    commit_cap.perm_w = perm_q[1];
    commit_cap.tag    = 1'b1;
  end

  ////////////////////
  // Operation issue
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      op_valid_q <= 1'b0;
    end else begin
      op_valid_q <= cmd_wr;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_wr) begin
      op_idx_q      <= pwdata_i[`CAP_IDX_W-1:0];
      op_is_write_q <= (paddr_i == `REG_CHK_GO) & pwdata_i[4];
      op_addr_q     <= chk_addr_q;
      op_cap_q      <= commit_cap;
      case (paddr_i)
        `REG_COMMIT: op_code_q <= OP_COMMIT;
        `REG_REVOKE: op_code_q <= OP_REVOKE;
        default:     op_code_q <= OP_CHECK;
      endcase
    end
  end

  assign op_o.valid    = op_valid_q;
  assign op_o.op       = op_code_q;
  assign op_o.idx      = op_idx_q;
  assign op_o.is_write = op_is_write_q;
  assign op_o.addr     = op_addr_q;
  assign op_o.cap      = op_cap_q;

  ////////////////////
  // Result and faults
  ////////////////////

  // A new check clears done even if an older verdict lands this cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      done_q      <= 1'b0;
      fault_q     <= FLT_NONE;
      fault_cnt_q <= '0;
    end else begin
      if (res_valid_i) begin
        done_q  <= 1'b1;
        fault_q <= res_fault_i;
        if (res_fault_i != FLT_NONE) begin
          fault_cnt_q <= fault_cnt_q + 32'd1;
        end
      end
      if (wr_en && (paddr_i == `REG_CHK_GO)) begin
        done_q <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/cap_op_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "cap_defs.svh"

interface cap_op_if;
  import cap_pkg::*;

  // One operation per cycle without back-pressure
  logic                  valid;
  cap_op_e               op;
  logic [`CAP_IDX_W-1:0] idx;
  logic                  is_write;
  logic [31:0]           addr;
  cap_t                  cap;

  modport src (
    output valid,
    output op,
    output idx,
    output is_write,
    output addr,
    output cap
  );

  modport dst (
    input  valid,
    input  op,
    input  idx,
    input  is_write,
    input  addr,
    input  cap
  );

endinterface

`default_nettype wire

// File: rtl/cap_pkg.sv
`default_nettype none

package cap_pkg;

  ////////////////////
  // Capability
  ////////////////////

  // Word range is [base, top) and tag marks a live entry
  typedef struct packed {
    logic [31:0] base;
    logic [31:0] top;
    logic        perm_r;
    logic        perm_w;
    logic        tag;
  } cap_t;

  ////////////////////
  // Pipeline ops
  ////////////////////

  typedef enum logic [1:0] {
    OP_COMMIT = 2'd0,
    OP_REVOKE = 2'd1,
    OP_CHECK  = 2'd2
  } cap_op_e;

  ////////////////////
  // Check verdict
  ////////////////////

  // Listed in decreasing priority after FLT_NONE
  typedef enum logic [1:0] {
    FLT_NONE   = 2'd0,
    FLT_TAG    = 2'd1,
    FLT_PERM   = 2'd2,
    FLT_BOUNDS = 2'd3
  } cap_fault_e;

endpackage

`default_nettype wire

// File: rtl/cap_defs.svh
`ifndef CAP_DEFS_SVH
`define CAP_DEFS_SVH

// Capability file geometry
`define CAP_NUM    16
`define CAP_IDX_W  4

// APB address width
`define CAP_ADDR_W 8

// Register map, word aligned
`define REG_BASE     8'h00
`define REG_LEN      8'h04
`define REG_PERM     8'h08
`define REG_COMMIT   8'h0C
`define REG_CHK_ADDR 8'h10
`define REG_CHK_GO   8'h14
`define REG_RESULT   8'h18
`define REG_REVOKE   8'h1C
`define REG_FAULTS   8'h20

`endif
